//--- logic/audioPkg.sv
package audioPkg;

	// ####################################################################
	// sound keys and FSM states
	// ####################################################################

	// key codes as seen by the tone generator.
	typedef enum logic [3:0] {
		keyShot   = 4'd1,
		keyHit    = 4'd6,
		keyEnemy  = 4'd9,
		keySilent = 4'd15
	} soundKeyT;

	typedef enum logic [2:0] {
		stIdle,
		stShot,
		stHit,
		stEnemy,
		stGameOver  // terminal, left only by reset.
	} audioStateT;

	// ####################################################################
	// durations and tone pitch
	// ####################################################################

	localparam int TIME_W = 11;  // duration word width.

	// sound lengths, counted in prescaled ticks.
	localparam int SHOT_TICKS  = 5;
	localparam int HIT_TICKS   = 8;
	localparam int ENEMY_TICKS = 6;

	// half-period of the square wave in clocks, zero when silent.
	function automatic int halfPeriodOf(soundKeyT key);
		case (key)
			keyShot:  return 3;
			keyHit:   return 5;
			keyEnemy: return 4;
			default:  return 0;
		endcase
	endfunction

endpackage

//--- logic/durationTimer.sv
module durationTimer
	import audioPkg::*;
#(
	parameter int clkDiv = 1000
) (
	input  logic              clk,
	input  logic              resetN,
	input  logic              requestTime,
	input  logic [TIME_W-1:0] timeAmount,
	output logic              timeUp
);

	localparam int preW = (clkDiv > 1) ? $clog2(clkDiv) : 1;

	logic [preW-1:0]   preCnt;   // clocks left in this tick.
	logic [TIME_W-1:0] tickCnt;  // ticks left, including the current one.
	logic              running;
	logic              tick;

	assign tick   = running && (preCnt == '0);
	assign timeUp = tick && (tickCnt == TIME_W'(1));  // last tick ends now.

	// ####################################################################
	// prescaler and tick counter
	// ####################################################################

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			preCnt  <= '0;
			tickCnt <= '0;
			running <= 1'b0;
		end else if (requestTime) begin  // reload restarts both counters.
			preCnt  <= preW'(clkDiv - 1);
			tickCnt <= timeAmount;
			running <= (timeAmount != '0);
		end else if (tick) begin
			preCnt  <= preW'(clkDiv - 1);
			tickCnt <= tickCnt - 1'b1;
			if (timeUp)
				running <= 1'b0;
		end else if (running) begin
			preCnt <= preCnt - 1'b1;
		end
	end

	aUpWhileRunning: assert property (@(posedge clk) disable iff (!resetN)
		timeUp |-> running);

endmodule

//--- logic/gameAudio.sv
module gameAudio
	import audioPkg::*;
#(
	parameter int clkDiv = 1000,
	parameter int halfW  = 16
) (
	input  logic       clk,
	input  logic       resetN,
	input  logic       shotFired,
	input  logic [2:0] enemyDead,
	input  logic       playerDead,
	input  logic       gameOver,
	output soundKeyT   soundKey,
	output logic       soundActive,
	output logic       audioOut
);

	logic              requestTime;
	logic [TIME_W-1:0] timeAmount;
	logic              timeUp;

	// ####################################################################
	// event FSM, duration timer, tone output
	// ####################################################################

	soundEventFsm u_soundEventFsm (
		.clk         (clk),
		.resetN      (resetN),
		.shotFired   (shotFired),
		.enemyDead   (enemyDead),
		.playerDead  (playerDead),
		.gameOver    (gameOver),
		.timeUp      (timeUp),
		.soundKey    (soundKey),
		.requestTime (requestTime),
		.timeAmount  (timeAmount)
	);

	durationTimer #(.clkDiv(clkDiv)) u_durationTimer (
		.clk         (clk),
		.resetN      (resetN),
		.requestTime (requestTime),
		.timeAmount  (timeAmount),
		.timeUp      (timeUp)
	);

	toneGenerator #(.halfW(halfW)) u_toneGenerator (
		.clk         (clk),
		.resetN      (resetN),
		.soundKey    (soundKey),
		.audioOut    (audioOut),
		.soundActive (soundActive)
	);

endmodule

//--- logic/soundEventFsm.sv
module soundEventFsm
	import audioPkg::*;
(
	input  logic              clk,
	input  logic              resetN,
	input  logic              shotFired,
	input  logic [2:0]        enemyDead,
	input  logic              playerDead,
	input  logic              gameOver,
	input  logic              timeUp,
	output soundKeyT          soundKey,
	output logic              requestTime,
	output logic [TIME_W-1:0] timeAmount
);

	audioStateT state, nextState;
	logic       accept;      // an event is taken this cycle.
	logic       anyEnemy;
	int         soundTicks;  // duration of the sound being entered.

	assign anyEnemy = |enemyDead;

	// ####################################################################
	// state register
	// ####################################################################

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= stIdle;
		end else begin
			state <= nextState;
		end
	end

	// ####################################################################
	// next state, event priority is gameOver, shot, enemy, hit
	// ####################################################################

	always_comb begin
		nextState = state;
		accept    = 1'b0;
		case (state)
			stIdle: begin
				accept = 1'b1;
				if (gameOver)        nextState = stGameOver;
				else if (shotFired)  nextState = stShot;
				else if (anyEnemy)   nextState = stEnemy;
				else if (playerDead) nextState = stHit;
				else                 accept = 1'b0;
			end
			stShot: begin  // a repeated shot does not restart the sound.
				accept = 1'b1;
				if (gameOver)        nextState = stGameOver;
				else if (anyEnemy)   nextState = stEnemy;
				else if (playerDead) nextState = stHit;
				else                 accept = 1'b0;
			end
			stEnemy: begin
				accept = 1'b1;
				if (gameOver)        nextState = stGameOver;
				else if (shotFired)  nextState = stShot;
				else if (playerDead) nextState = stHit;
				else                 accept = 1'b0;
			end
			stHit: begin  // hit sound always plays out.
				if (gameOver) begin
					nextState = stGameOver;
					accept    = 1'b1;
				end
			end
			stGameOver: nextState = stGameOver;
			default:    nextState = stIdle;
		endcase

		// an accepted event wins over the timer.
		if (!accept && timeUp && state inside {stShot, stHit, stEnemy})
			nextState = stIdle;
	end

	// duration request for the sound being entered.
	always_comb begin
		case (nextState)
			stShot:  soundTicks = SHOT_TICKS;
			stHit:   soundTicks = HIT_TICKS;
			stEnemy: soundTicks = ENEMY_TICKS;
			default: soundTicks = 0;
		endcase
	end

	assign requestTime = accept && (soundTicks != 0);
	assign timeAmount  = requestTime ? TIME_W'(soundTicks) : '0;

	// ####################################################################
	// sound key from state
	// ####################################################################

	always_comb begin
		case (state)
			stShot:  soundKey = keyShot;
			stHit:   soundKey = keyHit;
			stEnemy: soundKey = keyEnemy;
			default: soundKey = keySilent;  // idle and game over.
		endcase
	end

	// the timer would never fire on a zero load.
	aReqNonZero: assert property (@(posedge clk) disable iff (!resetN)
		requestTime |-> (timeAmount != '0));

	aGameOverHeld: assert property (@(posedge clk) disable iff (!resetN)
		(state == stGameOver) |=> (state == stGameOver));

endmodule

//--- logic/toneGenerator.sv
module toneGenerator
	import audioPkg::*;
#(
	parameter int halfW = 16
) (
	input  logic     clk,
	input  logic     resetN,
	input  soundKeyT soundKey,
	output logic     audioOut,
	output logic     soundActive
);

	soundKeyT         prevKey;     // key seen on the last clock.
	logic             keyChanged;
	logic             silent;
	logic [halfW-1:0] halfCnt;
	logic [halfW-1:0] reloadVal;
	logic             toneReg;
	int               halfPeriod;

	assign keyChanged  = (soundKey != prevKey);
	assign silent      = (soundKey == keySilent);
	assign soundActive = !silent;

	// ####################################################################
	// pitch lookup
	// ####################################################################

	always_comb begin
		halfPeriod = halfPeriodOf(soundKey);
		if (halfPeriod > 0)
			reloadVal = halfW'(halfPeriod - 1);
		else
			reloadVal = '0;
	end

	// ####################################################################
	// half-period counter and square wave
	// ####################################################################

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			prevKey <= keySilent;
			halfCnt <= '0;
			toneReg <= 1'b0;
		end else begin
			prevKey <= soundKey;
			if (keyChanged || silent) begin  // restart low on a new key.
				halfCnt <= reloadVal;
				toneReg <= 1'b0;
			end else if (halfCnt == '0) begin
				halfCnt <= reloadVal;
				toneReg <= ~toneReg;
			end else begin
				halfCnt <= halfCnt - 1'b1;
			end
		end
	end

	// forced low in the cycle the key changes.
	assign audioOut = toneReg && !keyChanged;

	aSilentLow: assert property (@(posedge clk) disable iff (!resetN)
		silent |-> !audioOut);

endmodule

//--- project.f
logic/audioPkg.sv
logic/soundEventFsm.sv
logic/durationTimer.sv
logic/toneGenerator.sv
logic/gameAudio.sv
verif/clockGen.sv
verif/gameAudioTb.sv

//--- verif/clockGen.sv
module clockGen #(
	parameter int period = 4
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(period / 2) clk = ~clk;  // free running.

endmodule

//--- verif/gameAudioTb.sv
module gameAudioTb
	import audioPkg::*;
();

	localparam int CLK_DIV     = 4;
	localparam int SOUND_LIMIT = 200;  // longest sound is 32 cycles.
	localparam int RAND_CYCLES = 3000;

	logic       clk;
	logic       resetN;
	logic       shotFired;
	logic [2:0] enemyDead;
	logic       playerDead;
	logic       gameOver;
	soundKeyT   soundKey;
	logic       soundActive;
	logic       audioOut;

	int checksDone   = 0;
	int errorCount   = 0;
	int timeoutCount = 0;
	bit timedOut     = 1'b0;
	int seedInit;

	soundKeyT seenKey;  // DUT key sampled at the last check.

	// model of the subsystem, values valid after the coming clock edge.
	audioStateT mState;
	int         mRemain;   // cycles left of the running duration.
	logic       mRunning;
	soundKeyT   mKey;
	int         mAge;      // cycles since the key last changed.

	clockGen #(.period(4)) u_clockGen (.clk(clk));

	gameAudio #(.clkDiv(CLK_DIV), .halfW(16)) u_gameAudio (
		.clk         (clk),
		.resetN      (resetN),
		.shotFired   (shotFired),
		.enemyDead   (enemyDead),
		.playerDead  (playerDead),
		.gameOver    (gameOver),
		.soundKey    (soundKey),
		.soundActive (soundActive),
		.audioOut    (audioOut)
	);

	// ####################################################################
	// compare tasks
	// ####################################################################

	task automatic checkKey(input string name, input soundKeyT expected, input soundKeyT actual);
		checksDone++;
		if (actual !== expected) begin
			errorCount++;
			$display("MISMATCH %s expected 0x%h actual 0x%h at %0t", name, expected, actual,
				$time);
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		checksDone++;
		if (actual !== expected) begin
			errorCount++;
			$display("MISMATCH %s expected 0x%h actual 0x%h at %0t", name, expected, actual,
				$time);
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		checksDone++;
		if (actual != expected) begin
			errorCount++;
			$display("MISMATCH %s expected 0x%h actual 0x%h at %0t", name, expected, actual,
				$time);
		end
	endtask

	task automatic reportTimeout(input string what);
		errorCount++;
		timeoutCount++;
		timedOut = 1'b1;
		$display("TIMEOUT: %s did not happen within %0d cycles", what, SOUND_LIMIT);
	endtask

	// ####################################################################
	// cycle model
	// ####################################################################

	function automatic soundKeyT keyOfState(input audioStateT s);
		case (s)
			stShot:  return keyShot;
			stHit:   return keyHit;
			stEnemy: return keyEnemy;
			default: return keySilent;
		endcase
	endfunction

	// pitch per sound, in clocks.
	function automatic int halfOfState(input audioStateT s);
		case (s)
			stShot:  return 3;
			stHit:   return 5;
			stEnemy: return 4;
			default: return 0;
		endcase
	endfunction

	function automatic int ticksOf(input audioStateT s);
		case (s)
			stShot:  return SHOT_TICKS;
			stHit:   return HIT_TICKS;
			stEnemy: return ENEMY_TICKS;
			default: return 0;
		endcase
	endfunction

	// low on the change cycle, then one toggle per half period.
	function automatic logic expAudio();
		int hp;
		if (mKey == keySilent || mAge == 0)
			return 1'b0;
		hp = halfOfState(mState);
		return (((mAge - 1) / hp) % 2) == 1;
	endfunction

	task automatic modelReset();
		mState   = stIdle;
		mRemain  = 0;
		mRunning = 1'b0;
		mKey     = keySilent;
		mAge     = 0;
	endtask

	task automatic modelStep(input logic shot, input logic [2:0] enemy, input logic hit,
		input logic over);
		logic       expire;
		logic       taken;
		audioStateT target;
		soundKeyT   newKey;
		expire = mRunning && (mRemain == 1);
		taken  = 1'b1;
		target = mState;
		if (over && mState != stGameOver)
			target = stGameOver;
		else if (shot && (mState == stIdle || mState == stEnemy))
			target = stShot;
		else if ((|enemy) && (mState == stIdle || mState == stShot))
			target = stEnemy;
		else if (hit && (mState == stIdle || mState == stShot || mState == stEnemy))
			target = stHit;
		else
			taken = 1'b0;

		if (mRunning) begin
			mRemain--;
			if (mRemain == 0)
				mRunning = 1'b0;
		end
		if (taken) begin
			mState = target;
			if (target != stGameOver) begin  // new sound restarts its duration.
				mRemain  = ticksOf(target) * CLK_DIV;
				mRunning = 1'b1;
			end
		end else if (expire && (mState == stShot || mState == stHit || mState == stEnemy)) begin
			mState = stIdle;
		end

		newKey = keyOfState(mState);
		if (newKey != mKey)
			mAge = 0;
		else
			mAge++;
		mKey = newKey;
	endtask

	// ####################################################################
	// stimulus tasks
	// ####################################################################

	// check this cycle, then drive the inputs for the next edge.
	task automatic stepCycle(input logic shot, input logic [2:0] enemy, input logic hit,
		input logic over);
		if (!timedOut) begin
			@(negedge clk);
			seenKey = soundKey;
			checkKey("soundKey", mKey, soundKey);
			checkBit("soundActive", mKey != keySilent, soundActive);
			checkBit("audioOut", expAudio(), audioOut);
			shotFired  = shot;
			enemyDead  = enemy;
			playerDead = hit;
			gameOver   = over;
			modelStep(shot, enemy, hit, over);
		end
	endtask

	task automatic applyReset();
		if (!timedOut) begin
			@(negedge clk);
			resetN     = 1'b0;
			shotFired  = 1'b0;
			enemyDead  = 3'd0;
			playerDead = 1'b0;
			gameOver   = 1'b0;
			repeat (5) @(negedge clk);
			checkKey("soundKey", keySilent, soundKey);
			checkBit("audioOut", 1'b0, audioOut);
			checkBit("soundActive", 1'b0, soundActive);
			resetN = 1'b1;
			modelReset();
			modelStep(1'b0, 3'd0, 1'b0, 1'b0);  // first edge out of reset.
		end
	endtask

	task automatic waitSilent(input string what);
		int guard;
		guard = 0;
		stepCycle(1'b0, 3'd0, 1'b0, 1'b0);
		while (!timedOut && seenKey != keySilent) begin
			guard++;
			if (guard > SOUND_LIMIT)
				reportTimeout(what);
			else
				stepCycle(1'b0, 3'd0, 1'b0, 1'b0);
		end
	endtask

	// counts the cycles a sound stays on after its event.
	task automatic countActive(input string what, output soundKeyT firstKey, output int cycles);
		int guard;
		guard  = 0;
		cycles = 0;
		stepCycle(1'b0, 3'd0, 1'b0, 1'b0);
		firstKey = seenKey;
		while (!timedOut && seenKey != keySilent) begin
			cycles++;
			guard++;
			if (guard > SOUND_LIMIT)
				reportTimeout(what);
			else
				stepCycle(1'b0, 3'd0, 1'b0, 1'b0);
		end
	endtask

	task automatic isolatedSound(input string name, input logic shot, input logic [2:0] enemy,
		input logic hit, input soundKeyT expKey, input int ticks);
		soundKeyT firstKey;
		int       cycles;
		waitSilent({"silence before ", name});
		stepCycle(shot, enemy, hit, 1'b0);
		countActive({name, " sound end"}, firstKey, cycles);
		if (!timedOut) begin
			checkKey({name, " soundKey"}, expKey, firstKey);
			checkCount({name, " duration"}, ticks * CLK_DIV, cycles);
		end
	endtask

	// sparse events, roughly one cycle in twenty.
	task automatic randomEvents(input int cycles, input logic over);
		logic       shot;
		logic [2:0] enemy;
		logic       hit;
		for (int i = 0; i < cycles; i++) begin
			shot  = 1'b0;
			enemy = 3'd0;
			hit   = 1'b0;
			if ($urandom_range(99) < 5) begin
				case ($urandom_range(3))
					0: shot = 1'b1;
					1: enemy = 3'($urandom_range(1, 7));
					2: hit = 1'b1;
					default: begin  // several at once, priority decides.
						shot  = 1'($urandom_range(1));
						enemy = 3'($urandom_range(7));
						hit   = 1'($urandom_range(1));
					end
				endcase
			end
			stepCycle(shot, enemy, hit, over);
		end
	endtask

	// ####################################################################
	// test sequence
	// ####################################################################

	initial begin
		soundKeyT firstKey;
		int       cycles;
		seedInit   = $urandom(23018);
		resetN     = 1'b0;
		shotFired  = 1'b0;
		enemyDead  = 3'd0;
		playerDead = 1'b0;
		gameOver   = 1'b0;
		modelReset();

		applyReset();

		// single events from silence.
		isolatedSound("shot", 1'b1, 3'd0, 1'b0, keyShot, SHOT_TICKS);
		isolatedSound("enemy", 1'b0, 3'd4, 1'b0, keyEnemy, ENEMY_TICKS);
		isolatedSound("hit", 1'b0, 3'd0, 1'b1, keyHit, HIT_TICKS);

		// shot preempts the enemy sound and restarts the duration.
		waitSilent("silence before preemption");
		stepCycle(1'b0, 3'd2, 1'b0, 1'b0);
		repeat (8) stepCycle(1'b0, 3'd0, 1'b0, 1'b0);
		stepCycle(1'b1, 3'd0, 1'b0, 1'b0);
		countActive("preempted shot end", firstKey, cycles);
		if (!timedOut) begin
			checkKey("preempting soundKey", keyShot, firstKey);
			checkCount("preempted shot duration", SHOT_TICKS * CLK_DIV, cycles);
		end

		// hit plays out, later events are dropped.
		stepCycle(1'b0, 3'd1, 1'b0, 1'b0);
		repeat (3) stepCycle(1'b0, 3'd0, 1'b0, 1'b0);
		stepCycle(1'b0, 3'd0, 1'b1, 1'b0);
		repeat (5) stepCycle(1'b0, 3'd0, 1'b0, 1'b0);
		stepCycle(1'b1, 3'd7, 1'b1, 1'b0);
		countActive("hit end", firstKey, cycles);
		if (!timedOut)
			checkCount("hit duration", HIT_TICKS * CLK_DIV, cycles + 6);

		randomEvents(RAND_CYCLES, 1'b0);

		// game over holds silence until reset.
		stepCycle(1'b1, 3'd0, 1'b0, 1'b1);
		randomEvents(50, 1'b1);
		randomEvents(200, 1'b0);
		if (!timedOut)
			checkKey("soundKey after game over", keySilent, seenKey);

		applyReset();
		isolatedSound("shot after reset", 1'b1, 3'd0, 1'b0, keyShot, SHOT_TICKS);

		$display("gameAudioTb: %0d checks, %0d errors, %0d timeouts", checksDone, errorCount,
			timeoutCount);
		if (errorCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
